// ==== hdl/gem_rx_pkg.sv ====
package gem_rx_pkg;

  // ---------------------------------------------------------------------------
  // fiber word and field types
  // ---------------------------------------------------------------------------

  typedef logic [15:0] gem_word_t;     // one decoded 16-bit fiber word
  typedef logic [7:0]  gem_kchar_t;    // frame counter in the K word high byte
  typedef logic [14:0] gem_cluster_t;  // {valid, pad address[10:0], size[2:0]}

  // ---------------------------------------------------------------------------
  // frame layout
  // ---------------------------------------------------------------------------

  localparam int         NUM_LINKS          = 4;      // fibers per super-chamber
  localparam int         FRAME_WORDS        = 8;      // words per frame
  localparam int         CLUSTERS_PER_FRAME = 2;      // cluster words per frame
  localparam logic [7:0] COMMA_BYTE         = 8'hBC;  // low byte of a K word
  localparam int         FIRST_CLUSTER_WORD = 1;      // word 1 holds cluster 0
  localparam int         WORD_POS_W         = $clog2(FRAME_WORDS);
  localparam int         CLUSTER_VALID_BIT  = 14;

  // merge slots, one per cluster of every link
  localparam int NUM_SLOTS  = NUM_LINKS * CLUSTERS_PER_FRAME;
  localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

  // ---------------------------------------------------------------------------
  // output side
  // ---------------------------------------------------------------------------

  localparam int FIFO_DEPTH  = 16;  // output FIFO entries
  localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
  localparam int CREDIT_INIT = 4;   // receive buffers downstream
  localparam int CREDIT_W    = $clog2(CREDIT_INIT + 1);

  // link alignment FSM
  typedef enum logic {
    HUNT,    // searching for a comma
    LOCKED   // aligned to frames
  } link_state_t;

endpackage

// ==== hdl/gem_link_rx.sv ====
`timescale 1ns/1ps

module gem_link_rx (
  input  logic                     clock,
  input  logic                     reset,
  input  gem_rx_pkg::gem_word_t    word,
  input  logic                     is_k,
  output logic                     locked,
  output gem_rx_pkg::gem_kchar_t   kchar,
  output logic                     frame_done,
  output gem_rx_pkg::gem_cluster_t cluster0,
  output gem_rx_pkg::gem_cluster_t cluster1
);
  import gem_rx_pkg::*;

  link_state_t           state;     // alignment FSM
  logic [WORD_POS_W-1:0] pos;       // position of the word sampled now
  logic                  is_comma;  // K flag plus comma byte
  logic                  accept_k;  // comma where one is expected
  logic                  last_pos;  // final word of the frame
  logic                  data_word; // non-comma word while locked

  assign is_comma  = is_k && (word[7:0] == COMMA_BYTE);
  assign accept_k  = is_comma && ((state == HUNT) || (pos == '0));
  assign last_pos  = (pos == WORD_POS_W'(FRAME_WORDS - 1));
  assign data_word = (state == LOCKED) && !is_comma;
  assign locked    = (state == LOCKED);

  // ---------------------------------------------------------------------------
  // alignment and frame counter
  // ---------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= HUNT;
      pos        <= '0;
      kchar      <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;                          // single-cycle pulse
      if (accept_k) begin
        state <= LOCKED;                           // comma marks word 0
        pos   <= WORD_POS_W'(1);
        kchar <= word[15:8];                       // latest frame counter
      end else if (state == LOCKED) begin
        if (is_comma || (pos == '0)) begin
          state <= HUNT;                           // misplaced or missing comma
          pos   <= '0;
        end else begin
          pos        <= last_pos ? '0 : pos + 1'b1;
          frame_done <= (pos == WORD_POS_W'(FIRST_CLUSTER_WORD + 1));
        end
      end
    end
  end

  // cluster capture, words 1 and 2 of a locked frame
  always_ff @(posedge clock) begin
    if (data_word && (pos == WORD_POS_W'(FIRST_CLUSTER_WORD))) begin
      cluster0 <= word[14:0];                      // top bit of the word dropped
    end
    if (data_word && (pos == WORD_POS_W'(FIRST_CLUSTER_WORD + 1))) begin
      cluster1 <= word[14:0];
    end
  end

  // a done pulse always belongs to a frame that is still aligned
  a_done_locked : assert property (
    @(posedge clock) disable iff (reset)
    frame_done |-> locked
  );

endmodule

// ==== hdl/gem_sync_mon.sv ====
`timescale 1ns/1ps

module gem_sync_mon (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   ttc_resync,
  input  gem_rx_pkg::gem_kchar_t kchar0,
  input  gem_rx_pkg::gem_kchar_t kchar1,
  input  gem_rx_pkg::gem_kchar_t kchar2,
  input  gem_rx_pkg::gem_kchar_t kchar3,
  output logic                   synced_a,
  output logic                   synced_b,
  output logic                   synced_all,
  output logic                   lost_a,
  output logic                   lost_b,
  output logic                   lost_all
);

  logic match_a;    // both fibers of chamber A agree
  logic match_b;    // both fibers of chamber B agree
  logic match_all;  // whole super-chamber agrees
  logic clear;      // restart the monitor

  assign match_a   = (kchar0 == kchar1);
  assign match_b   = (kchar2 == kchar3);
  assign match_all = match_a && match_b && (kchar0 == kchar2);
  assign clear     = reset || ttc_resync;

  // ---------------------------------------------------------------------------
  // live flags and sticky loss flags
  // ---------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (clear) begin
      synced_a   <= 1'b1;             // assume sync until shown otherwise
      synced_b   <= 1'b1;
      synced_all <= 1'b1;
      lost_a     <= 1'b0;
      lost_b     <= 1'b0;
      lost_all   <= 1'b0;
    end else begin
      synced_a   <= match_a;          // follows kchars by one cycle
      synced_b   <= match_b;
      synced_all <= match_all;
      lost_a     <= lost_a | ~match_a;   // set with the live drop
      lost_b     <= lost_b | ~match_b;
      lost_all   <= lost_all | ~match_all;
    end
  end

endmodule

// ==== hdl/gem_cluster_merge.sv ====
`timescale 1ns/1ps

module gem_cluster_merge (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [3:0]               frame_done,
  input  gem_rx_pkg::gem_cluster_t cluster0_0,
  input  gem_rx_pkg::gem_cluster_t cluster0_1,
  input  gem_rx_pkg::gem_cluster_t cluster1_0,
  input  gem_rx_pkg::gem_cluster_t cluster1_1,
  input  gem_rx_pkg::gem_cluster_t cluster2_0,
  input  gem_rx_pkg::gem_cluster_t cluster2_1,
  input  gem_rx_pkg::gem_cluster_t cluster3_0,
  input  gem_rx_pkg::gem_cluster_t cluster3_1,
  input  logic                     fifo_full,
  output logic                     wr_en,
  output gem_rx_pkg::gem_cluster_t wr_cluster,
  output logic                     overflow
);
  import gem_rx_pkg::*;

  gem_cluster_t          in_cl   [NUM_SLOTS];  // incoming clusters in link order
  gem_cluster_t          slot_cl [NUM_SLOTS];  // held clusters
  logic [NUM_SLOTS-1:0]  pend;                 // valid and not yet sent
  logic [NUM_SLOTS-1:0]  grant;                // slot sent this cycle
  logic [SLOT_IDX_W-1:0] head;                 // lowest pending slot
  logic                  any_pend;

  assign in_cl[0] = cluster0_0;
  assign in_cl[1] = cluster0_1;
  assign in_cl[2] = cluster1_0;
  assign in_cl[3] = cluster1_1;
  assign in_cl[4] = cluster2_0;
  assign in_cl[5] = cluster2_1;
  assign in_cl[6] = cluster3_0;
  assign in_cl[7] = cluster3_1;

  // ---------------------------------------------------------------------------
  // fixed-priority scanner
  // ---------------------------------------------------------------------------

  always_comb begin
    head     = '0;
    any_pend = 1'b0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin  // last hit is the lowest index
      if (pend[i]) begin
        head     = SLOT_IDX_W'(i);
        any_pend = 1'b1;
      end
    end
  end

  assign wr_en      = any_pend && !fifo_full;       // head held while full
  assign wr_cluster = slot_cl[head];
  assign grant      = wr_en ? (NUM_SLOTS'(1) << head) : '0;

  // slot payload
  always_ff @(posedge clock) begin
    for (int l = 0; l < NUM_LINKS; l++) begin
      for (int c = 0; c < CLUSTERS_PER_FRAME; c++) begin
        if (frame_done[l]) begin
          slot_cl[l * CLUSTERS_PER_FRAME + c] <= in_cl[l * CLUSTERS_PER_FRAME + c];
        end
      end
    end
  end

  // pending bits and overrun
  always_ff @(posedge clock) begin
    if (reset) begin
      pend     <= '0;
      overflow <= 1'b0;
    end else begin
      for (int l = 0; l < NUM_LINKS; l++) begin
        for (int c = 0; c < CLUSTERS_PER_FRAME; c++) begin
          if (frame_done[l]) begin
            // invalid clusters never become pending so they cost no cycle
            pend[l * CLUSTERS_PER_FRAME + c] <=
              in_cl[l * CLUSTERS_PER_FRAME + c][CLUSTER_VALID_BIT];
            if (pend[l * CLUSTERS_PER_FRAME + c] && !grant[l * CLUSTERS_PER_FRAME + c]) begin
              overflow <= 1'b1;                     // unsent cluster overwritten
            end
          end else if (grant[l * CLUSTERS_PER_FRAME + c]) begin
            pend[l * CLUSTERS_PER_FRAME + c] <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== hdl/gem_credit_tx.sv ====
`timescale 1ns/1ps

module gem_credit_tx (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     wr_en,
  input  gem_rx_pkg::gem_cluster_t wr_cluster,
  output logic                     fifo_full,
  input  logic                     credit_return,
  output logic                     out_valid,
  output gem_rx_pkg::gem_cluster_t out_cluster
);
  import gem_rx_pkg::*;

  gem_cluster_t        mem [FIFO_DEPTH];  // FIFO storage
  logic [FIFO_AW-1:0]  wr_ptr;
  logic [FIFO_AW-1:0]  rd_ptr;
  logic [FIFO_AW:0]    count;             // entries held
  logic [CREDIT_W-1:0] credits;           // free buffers downstream
  logic                fifo_empty;
  logic                rd_en;             // pop and send this cycle

  assign fifo_empty = (count == '0);
  assign fifo_full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign rd_en      = !fifo_empty && (credits != '0);   // credit gates the read

  // ---------------------------------------------------------------------------
  // FIFO
  // ---------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_cluster;
    end
    if (rd_en) begin
      out_cluster <= mem[rd_ptr];         // valid with out_valid
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;          // wraps at depth
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // credit counter and send strobe
  // ---------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      credits   <= CREDIT_W'(CREDIT_INIT);  // all buffers free
      out_valid <= 1'b0;
    end else begin
      out_valid <= rd_en;
      case ({rd_en, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;        // spend and return cancel
      endcase
    end
  end

  // downstream returns no more buffers than it owns
  a_credit_max : assert property (
    @(posedge clock) disable iff (reset)
    credits <= CREDIT_W'(CREDIT_INIT)
  );

  // every send was paid for with a credit
  a_send_credit : assert property (
    @(posedge clock) disable iff (reset)
    out_valid |-> ($past(credits) != '0)
  );

  // the merge must stall on a full FIFO
  a_no_write_full : assert property (
    @(posedge clock) disable iff (reset)
    wr_en |-> !fifo_full
  );

endmodule

// ==== hdl/gem_rx_top.sv ====
`timescale 1ns/1ps

module gem_rx_top (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     ttc_resync,
  input  gem_rx_pkg::gem_word_t    link_word0,
  input  gem_rx_pkg::gem_word_t    link_word1,
  input  gem_rx_pkg::gem_word_t    link_word2,
  input  gem_rx_pkg::gem_word_t    link_word3,
  input  logic [3:0]               link_is_k,
  output logic [3:0]               locked,
  output logic                     synced_a,
  output logic                     synced_b,
  output logic                     synced_all,
  output logic                     lost_a,
  output logic                     lost_b,
  output logic                     lost_all,
  output logic                     overflow,
  output logic                     out_valid,
  output gem_rx_pkg::gem_cluster_t out_cluster,
  input  logic                     credit_return
);
  import gem_rx_pkg::*;

  gem_word_t            link_word [NUM_LINKS];  // fiber words by index
  gem_kchar_t           kchar     [NUM_LINKS];
  gem_cluster_t         cl0       [NUM_LINKS];  // first cluster of each frame
  gem_cluster_t         cl1       [NUM_LINKS];  // second cluster of each frame
  logic [NUM_LINKS-1:0] frame_done;
  logic                 wr_en;
  gem_cluster_t         wr_cluster;
  logic                 fifo_full;

  assign link_word[0] = link_word0;
  assign link_word[1] = link_word1;
  assign link_word[2] = link_word2;
  assign link_word[3] = link_word3;

  // ---------------------------------------------------------------------------
  // per-fiber alignment
  // ---------------------------------------------------------------------------

  for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
    gem_link_rx u_link_rx (
      .clock      (clock),
      .reset      (reset),
      .word       (link_word[i]),
      .is_k       (link_is_k[i]),
      .locked     (locked[i]),
      .kchar      (kchar[i]),
      .frame_done (frame_done[i]),
      .cluster0   (cl0[i]),
      .cluster1   (cl1[i])
    );
  end

  gem_sync_mon u_sync_mon (
    .clock      (clock),
    .reset      (reset),
    .ttc_resync (ttc_resync),
    .kchar0     (kchar[0]),
    .kchar1     (kchar[1]),
    .kchar2     (kchar[2]),
    .kchar3     (kchar[3]),
    .synced_a   (synced_a),
    .synced_b   (synced_b),
    .synced_all (synced_all),
    .lost_a     (lost_a),
    .lost_b     (lost_b),
    .lost_all   (lost_all)
  );

  // ---------------------------------------------------------------------------
  // cluster collection and output
  // ---------------------------------------------------------------------------

  gem_cluster_merge u_merge (
    .clock      (clock),
    .reset      (reset),
    .frame_done (frame_done),
    .cluster0_0 (cl0[0]),
    .cluster0_1 (cl1[0]),
    .cluster1_0 (cl0[1]),
    .cluster1_1 (cl1[1]),
    .cluster2_0 (cl0[2]),
    .cluster2_1 (cl1[2]),
    .cluster3_0 (cl0[3]),
    .cluster3_1 (cl1[3]),
    .fifo_full  (fifo_full),
    .wr_en      (wr_en),
    .wr_cluster (wr_cluster),
    .overflow   (overflow)
  );

  gem_credit_tx u_credit_tx (
    .clock         (clock),
    .reset         (reset),
    .wr_en         (wr_en),
    .wr_cluster    (wr_cluster),
    .fifo_full     (fifo_full),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_cluster   (out_cluster)
  );

endmodule

// ==== sim/gem_rx_tb.sv ====
`timescale 1ns/1ps

module gem_rx_tb;
  import gem_rx_pkg::*;

  localparam int NUM_ROWS    = 12;
  localparam int CLK_NS      = 8;
  localparam int WATCHDOG_NS = NUM_ROWS * FRAME_WORDS * CLK_NS * 4 + 2000;
  localparam int NO_LINK     = -1;  // row without a misplaced comma
  localparam int MISP_POS    = 3;   // where a misplaced comma lands

  logic         clock, reset, ttc_resync, credit_return;
  gem_word_t    link_word [NUM_LINKS];
  logic [3:0]   link_is_k, locked;
  logic         synced_a, synced_b, synced_all, lost_a, lost_b, lost_all;
  logic         overflow, out_valid;
  gem_cluster_t out_cluster;

  // frame table, one row per frame on all four fibers
  gem_kchar_t           kchar_tab  [NUM_ROWS][NUM_LINKS];
  logic [NUM_SLOTS-1:0] valid_tab  [NUM_ROWS];             // bit = link*2 + cluster
  int                   misp_tab   [NUM_ROWS];
  logic                 resync_tab [NUM_ROWS];
  logic                 hold_tab   [NUM_ROWS];
  gem_cluster_t         cl_tab     [NUM_ROWS][NUM_SLOTS];

  gem_cluster_t exp_q [$];     // clusters still owed by the DUT
  int           ret_due [$];   // cycles at which credits go back
  int           cycle, outstanding;
  logic         hold;          // downstream keeps its buffers
  logic         lost_a_m, lost_b_m, lost_all_m;  // sticky loss model
  logic [31:0]  lcg_state;

  gem_rx_top UUT (
    .clock (clock), .reset (reset), .ttc_resync (ttc_resync),
    .link_word0 (link_word[0]), .link_word1 (link_word[1]),
    .link_word2 (link_word[2]), .link_word3 (link_word[3]),
    .link_is_k (link_is_k), .locked (locked),
    .synced_a (synced_a), .synced_b (synced_b), .synced_all (synced_all),
    .lost_a (lost_a), .lost_b (lost_b), .lost_all (lost_all),
    .overflow (overflow), .out_valid (out_valid), .out_cluster (out_cluster),
    .credit_return (credit_return)
  );

  initial clock = 1'b0;
  always #(CLK_NS / 2) clock = ~clock;

  // --------------------------------------------------------------------------
  // helpers and checks
  // --------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_run(string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_cluster(string name, gem_cluster_t got, gem_cluster_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // a link drops its frame with the misplaced comma and the frame after it
  function automatic logic link_lost(int r, int l);
    if (misp_tab[r] == l) return 1'b1;
    if (r > 0) return misp_tab[r - 1] == l;
    return 1'b0;
  endfunction

  task automatic set_row(int r, gem_kchar_t k0, k1, k2, k3, logic [NUM_SLOTS-1:0] vmask,
                         int misp, logic resync, logic hold_row);
    logic [31:0] rnd;
    kchar_tab[r][0] = k0;
    kchar_tab[r][1] = k1;
    kchar_tab[r][2] = k2;
    kchar_tab[r][3] = k3;
    valid_tab[r]    = vmask;
    misp_tab[r]     = misp;
    resync_tab[r]   = resync;
    hold_tab[r]     = hold_row;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      rnd          = lcg_next();
      cl_tab[r][i] = {vmask[i], rnd[29:16]};  // random pad and size
    end
  endtask

  task automatic build_expected();
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        if (valid_tab[r][s] && !link_lost(r, s / CLUSTERS_PER_FRAME)) begin
          exp_q.push_back(cl_tab[r][s]);   // link order, then cluster order
        end
      end
    end
  endtask

  // one clock step plus the downstream receiver
  task automatic tick();
    gem_cluster_t exp_cl;
    @(posedge clock);
    #1;
    credit_return = 1'b0;                  // pulses last one cycle
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        fail_run("a cluster came out when none was expected");
      end else begin
        exp_cl = exp_q.pop_front();
        check_cluster("out_cluster", out_cluster, exp_cl);
        outstanding++;
        ret_due.push_back(cycle + 1 + int'((lcg_next() >> 16) % 6));  // 1 to 6 cycles
      end
    end
    if (outstanding > CREDIT_INIT) begin
      fail_run($sformatf("%0d clusters sent with no credit returned", outstanding));
    end
    if (!hold && ret_due.size() > 0 && ret_due[0] <= cycle) begin
      void'(ret_due.pop_front());
      credit_return = 1'b1;
      outstanding--;
    end
    cycle++;
  endtask

  task automatic drive_word(int r, int w);
    int kpos;
    for (int l = 0; l < NUM_LINKS; l++) begin
      kpos         = (misp_tab[r] == l) ? MISP_POS : 0;
      link_is_k[l] = (w == kpos);
      if (w == kpos) begin
        link_word[l] = {kchar_tab[r][l], COMMA_BYTE};
      end else if (w >= 1 && w <= CLUSTERS_PER_FRAME) begin
        link_word[l] = {1'b0, cl_tab[r][l * CLUSTERS_PER_FRAME + w - 1]};
      end else begin
        link_word[l] = '0;                 // idle word, valid bit clear
      end
    end
  endtask

  task automatic check_sync(int r, logic after_resync);
    logic exp_a, exp_b, exp_all;
    exp_a   = (kchar_tab[r][0] == kchar_tab[r][1]);
    exp_b   = (kchar_tab[r][2] == kchar_tab[r][3]);
    exp_all = exp_a && exp_b && (kchar_tab[r][0] == kchar_tab[r][2]);
    lost_a_m   = (after_resync ? 1'b0 : lost_a_m) | !exp_a;
    lost_b_m   = (after_resync ? 1'b0 : lost_b_m) | !exp_b;
    lost_all_m = (after_resync ? 1'b0 : lost_all_m) | !exp_all;
    check_flag("synced_a", synced_a, exp_a);
    check_flag("synced_b", synced_b, exp_b);
    check_flag("synced_all", synced_all, exp_all);
    check_flag("lost_a", lost_a, lost_a_m);
    check_flag("lost_b", lost_b, lost_b_m);
    check_flag("lost_all", lost_all, lost_all_m);
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  initial begin
    $timeformat(-9, 0, " ns", 0);
    lcg_state     = 32'hc3c0_08d5;
    reset         = 1'b1;
    ttc_resync    = 1'b0;
    credit_return = 1'b0;
    link_is_k     = '0;
    link_word     = '{default: '0};
    cycle         = 0;
    outstanding   = 0;
    hold          = 1'b0;
    lost_a_m      = 1'b0;
    lost_b_m      = 1'b0;
    lost_all_m    = 1'b0;
    //      row kchar0 kchar1 kchar2 kchar3 valid        misplaced resync hold
    set_row(0,  8'h10, 8'h10, 8'h10, 8'h10, 8'b1010_0101, NO_LINK, 1'b0, 1'b0);
    set_row(1,  8'h11, 8'h11, 8'h11, 8'h11, 8'b1111_0000, NO_LINK, 1'b0, 1'b0);
    set_row(2,  8'h12, 8'h13, 8'h12, 8'h12, 8'b0000_0000, NO_LINK, 1'b0, 1'b0);
    set_row(3,  8'h14, 8'h14, 8'h14, 8'h14, 8'b0110_1001, NO_LINK, 1'b0, 1'b0);
    set_row(4,  8'h15, 8'h15, 8'h15, 8'h15, 8'b1000_0001, NO_LINK, 1'b1, 1'b0);
    set_row(5,  8'h16, 8'h16, 8'h16, 8'h17, 8'b0011_1100, NO_LINK, 1'b0, 1'b0);
    set_row(6,  8'h18, 8'h18, 8'h19, 8'h19, 8'b1111_1111, NO_LINK, 1'b0, 1'b0);
    set_row(7,  8'h20, 8'h20, 8'h20, 8'h20, 8'b0101_0101, NO_LINK, 1'b1, 1'b0);
    set_row(8,  8'h20, 8'h20, 8'h20, 8'h20, 8'b1111_1111, 2,       1'b0, 1'b0);
    set_row(9,  8'h20, 8'h20, 8'h20, 8'h20, 8'b0011_0011, NO_LINK, 1'b0, 1'b0);
    set_row(10, 8'h22, 8'h22, 8'h22, 8'h22, 8'b1111_1111, NO_LINK, 1'b0, 1'b1);
    set_row(11, 8'h23, 8'h23, 8'h23, 8'h23, 8'b1100_0011, NO_LINK, 1'b0, 1'b0);
    build_expected();
    repeat (5) tick();
    reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      hold = hold_tab[r];
      for (int w = 0; w < FRAME_WORDS; w++) begin
        tick();
        if (w == 2) begin
          for (int l = 0; l < NUM_LINKS; l++) begin
            check_flag($sformatf("locked[%0d]", l), locked[l], !link_lost(r, l));
          end
        end
        if (w == 4) check_sync(r, 1'b0);     // kchars of this frame settled
        if (w == 7) begin
          if (resync_tab[r]) check_sync(r, 1'b1);
          check_flag("overflow", overflow, 1'b0);
        end
        ttc_resync = resync_tab[r] && (w == 5);
        drive_word(r, w);
      end
    end
    hold = 1'b0;                             // release held credits
    while (exp_q.size() > 0) tick();
    repeat (16) tick();                      // nothing extra may follow
    check_flag("overflow", overflow, 1'b0);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired with %0d clusters still expected", exp_q.size());
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

endmodule

// ==== gem_rx.f ====
hdl/gem_rx_pkg.sv
hdl/gem_link_rx.sv
hdl/gem_sync_mon.sv
hdl/gem_cluster_merge.sv
hdl/gem_credit_tx.sv
hdl/gem_rx_top.sv
sim/gem_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gem_rx_tb
FLIST     ?= gem_rx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
